// File: Makefile
# Verilator build and run of the ALU core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_rv_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/rv_ref_model.svh
/* Reference model for the ALU core testbench with model registers, expected
   results and a random instruction generator. Included inside the testbench. */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [rv_isa_pkg::xlen-1:0] model_regs [rv_isa_pkg::num_regs];

// mostly a small hot set so instructions depend on each other
function automatic logic [4:0] pick_reg();
    int unsigned r;
    r = $urandom % 16;
    if (r < 10)
        return 5'($urandom % 4 + 1);
    else if (r < 11)
        return 5'd0;
    else
        return 5'($urandom % 32);
endfunction

// one OP or OP-IMM instruction with the given funct3
function automatic logic [31:0] random_alu(input logic reg_form, input logic [2:0] f3,
                                           input logic alt);
    logic [6:0]  f7;
    logic [11:0] imm;
    f7  = alt ? rv_isa_pkg::funct7_alt : 7'b0;
    imm = (f3 == 3'b001 || f3 == 3'b101) ? {f7, 5'($urandom)} : 12'($urandom);
    if (reg_form)
        return {f7, pick_reg(), pick_reg(), f3, pick_reg(), rv_isa_pkg::op_op};
    else
        return {imm, pick_reg(), f3, pick_reg(), rv_isa_pkg::op_imm};
endfunction

function automatic logic [31:0] random_inst();
    int unsigned kind;
    logic [2:0]  f3;
    logic [6:0]  opc;
    kind = $urandom % 16;
    f3   = 3'($urandom);
    opc  = 7'($urandom);
    if (kind < 12) begin
        return random_alu(kind < 6, f3,
                          (f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2 != 0));
    end else if (kind < 14) begin
        return {20'($urandom), pick_reg(), rv_isa_pkg::op_lui};
    end else begin
        if (opc == rv_isa_pkg::op_op || opc == rv_isa_pkg::op_imm || opc == rv_isa_pkg::op_lui)
            opc = 7'b1111111;  // keep it unsupported
        return {25'($urandom), opc};
    end
endfunction

// expected rd and value per RV32I with rd 0 outside OP, OP-IMM and LUI
function automatic void ref_result(input logic [31:0] ins, output logic [4:0] rd,
                                   output logic [31:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  opc;
    logic        alt;
    opc = ins[6:0];
    alt = (ins[31:25] == rv_isa_pkg::funct7_alt);
    a   = model_regs[ins[19:15]];
    b   = (opc == rv_isa_pkg::op_op) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    rd  = ins[11:7];
    val = '0;
    if (opc == rv_isa_pkg::op_lui) begin
        val = {ins[31:12], 12'b0};
    end else if (opc == rv_isa_pkg::op_op || opc == rv_isa_pkg::op_imm) begin
        case (ins[14:12])
            3'b000: val = (opc == rv_isa_pkg::op_op && alt) ? a - b : a + b;
            3'b001: val = a << b[4:0];
            3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: val = (a < b) ? 32'd1 : 32'd0;
            3'b100: val = a ^ b;
            3'b101: begin
                if (alt)
                    val = $signed(a) >>> b[4:0];
                else
                    val = a >> b[4:0];
            end
            3'b110: val = a | b;
            default: val = a & b;
        endcase
    end else begin
        rd = '0;
    end
endfunction

`endif

// File: sim/tb_rv_core.sv
/* Testbench for the ALU core with directed and random instruction streams,
   pauses and commit back-pressure, checked in order against a reference model. */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int wait_limit = 100 * core_pkg::pipe_depth + 100;  // cycles per wait

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    logic                                 rdy = 1'b1;
    logic                                 inst_valid;
    logic                                 inst_ready;
    logic [rv_isa_pkg::inst_width-1:0]    inst;
    logic                                 commit_valid;
    logic                                 commit_ready = 1'b0;
    logic [rv_isa_pkg::reg_idx_width-1:0] commit_rd;
    logic [rv_isa_pkg::xlen-1:0]          commit_data;
    logic [rv_isa_pkg::reg_idx_width-1:0] dbg_sel;
    logic [rv_isa_pkg::xlen-1:0]          dbg_data;

    logic        bp_on = 1'b0;
    logic        pause_on = 1'b0;
    int          value_errors = 0;
    int          proto_errors = 0;
    int          accepted = 0;
    int          committed = 0;
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic        held = 1'b0;  // commit stalled last time it was seen
    logic [4:0]  held_rd;
    logic [31:0] held_data;

    `include "rv_ref_model.svh"

    rv_core i_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdy          (rdy),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .dbg_sel      (dbg_sel),
        .dbg_data     (dbg_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        commit_ready <= bp_on ? ($urandom % 4 != 0) : 1'b1;
        rdy          <= pause_on ? ($urandom % 5 != 0) : 1'b1;
    end

    task automatic finish_run();
        $display("accepted %0d, committed %0d, value errors %0d, protocol errors %0d",
                 accepted, committed, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    task automatic stop_on_timeout(input string why);
        $display("timeout at %0t: %s", $time, why);
        proto_errors++;
        finish_run();
    endtask

    task automatic check_commit();
        logic [4:0]  rd;
        logic [31:0] data;
        if (exp_rd_q.size() == 0) begin
            $display("commit of x%0d at %0t with no instruction pending", commit_rd, $time);
            proto_errors++;
        end else begin
            rd   = exp_rd_q.pop_front();
            data = exp_data_q.pop_front();
            committed++;
            if (commit_rd != rd) begin
                $display("[FAIL] %0t: commit rd x%0d, expected x%0d", $time, commit_rd, rd);
                value_errors++;
            end else if (rd != '0 && commit_data != data) begin
                $display("[FAIL] %0t: x%0d got %h, expected %h", $time, rd, commit_data, data);
                value_errors++;
            end
        end
    endtask

    // compare process on the pre-edge values of all DUT outputs
    always @(posedge clk) begin
        if (rst_n) begin
            if (!rdy && (inst_ready || commit_valid)) begin
                $display("[FAIL] %0t: handshake active while rdy is low", $time);
                proto_errors++;
            end
            if (held && commit_valid && (commit_rd != held_rd || commit_data != held_data)) begin
                $display("[FAIL] %0t: commit payload changed while stalled", $time);
                proto_errors++;
            end
            if (commit_valid && commit_ready && rdy) begin
                held = 1'b0;
                check_commit();
            end else if (commit_valid) begin
                held      = 1'b1;
                held_rd   = commit_rd;
                held_data = commit_data;
            end
        end
    end

    // present one instruction and hold it until the transfer
    task automatic send(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] val;
        int          cycles;
        inst_valid <= 1'b1;
        inst       <= ins;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!(inst_ready && rdy) && cycles < wait_limit);
        if (!(inst_ready && rdy)) begin
            stop_on_timeout("instruction was not accepted");
        end else begin
            ref_result(ins, rd, val);
            if (rd != '0)
                model_regs[rd] = val;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(val);
            accepted++;
        end
    endtask

    task automatic idle();
        inst_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drain();
        int cycles;
        inst_valid <= 1'b0;
        cycles = 0;
        while (exp_rd_q.size() != 0 && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd_q.size() != 0)
            stop_on_timeout("pipeline did not drain its commits");
        else
            repeat (2) @(posedge clk);
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < rv_isa_pkg::num_regs; i++) begin
            dbg_sel <= 5'(i);
            @(posedge clk);
            if (dbg_data !== model_regs[5'(i)]) begin
                $display("[FAIL] %0t: x%0d reads %h, expected %h",
                         $time, i, dbg_data, model_regs[5'(i)]);
                value_errors++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hfc2a));
        rst_n      <= 1'b0;
        inst_valid <= 1'b0;
        inst       <= '0;
        dbg_sel    <= '0;
        for (int i = 0; i < rv_isa_pkg::num_regs; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (commit_valid || !inst_ready) begin
            $display("[FAIL] %0t: wrong handshake state after reset", $time);
            proto_errors++;
        end
        sweep_regs();

        // load random values, then every ALU op in both forms
        for (int r = 1; r < 8; r++) begin
            send({20'($urandom), 5'(r), rv_isa_pkg::op_lui});
            send({12'($urandom), 5'(r), 3'b000, 5'(r), rv_isa_pkg::op_imm});
        end
        for (int f = 0; f < 8; f++) begin
            send(random_alu(1'b1, 3'(f), 1'b0));
            send(random_alu(1'b0, 3'(f), 1'b0));
            if (f == 0 || f == 5) begin
                send(random_alu(1'b1, 3'(f), 1'b1));
                send(random_alu(1'b0, 3'(f), 1'b1));
            end
        end

        // x1 comes from the decode register, x2 from the result register
        for (int k = 0; k < 16; k++) begin
            send({12'($urandom), 5'd1, 3'b000, 5'd1, rv_isa_pkg::op_imm});
            send({7'b0, 5'd1, 5'd2, 3'b000, 5'd2, rv_isa_pkg::op_op});
        end

        bp_on <= 1'b1;
        for (int n = 0; n < 400; n++) begin
            send(random_inst());
            if ($urandom % 8 == 0)
                idle();
        end
        pause_on <= 1'b1;
        for (int n = 0; n < 400; n++)
            send(random_inst());
        drain();
        sweep_regs();
        finish_run();
    end

endmodule

// File: src.f
+incdir+sim
src/rv_isa_pkg.sv
src/core_pkg.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_core.sv
sim/tb_rv_core.sv

// File: src/core_pkg.sv
/* Micro-architecture definitions of the in-order ALU core. */
package core_pkg;

    // operation carried from decode to execute
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    localparam int pipe_depth = 2;  // register stages from accept to commit

endpackage

// File: src/decode_stage.sv
/* Decode stage that turns the instruction into an ALU operation with bypassed
   operands and holds it in the decode register until execute takes it. */
`timescale 1ns/1ps

module decode_stage (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rdy,
    input  logic                                   inst_valid,
    output logic                                   inst_ready,
    input  logic [rv_isa_pkg::inst_width-1:0]      inst,
    input  logic                                   ex_ready,
    input  logic                                   fwd_valid,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   fwd_rd,
    input  logic [rv_isa_pkg::xlen-1:0]            fwd_data,
    input  logic                                   res_valid,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   res_rd,
    input  logic [rv_isa_pkg::xlen-1:0]            res_data,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   rs1_sel,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   rs2_sel,
    input  logic [rv_isa_pkg::xlen-1:0]            rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]            rs2_data,
    output logic                                   dec_valid,
    output core_pkg::alu_op_e                      dec_op,
    output logic [rv_isa_pkg::xlen-1:0]            dec_a,
    output logic [rv_isa_pkg::xlen-1:0]            dec_b,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   dec_rd
);

    rv_isa_pkg::opcode_e                   opcode;
    rv_isa_pkg::funct3_e                   funct3;
    logic                                  alt;
    logic [rv_isa_pkg::xlen-1:0]           imm_i;
    logic [rv_isa_pkg::xlen-1:0]           imm_u;
    logic [rv_isa_pkg::xlen-1:0]           src1;
    logic [rv_isa_pkg::xlen-1:0]           src2;
    core_pkg::alu_op_e                     op_d;
    logic [rv_isa_pkg::xlen-1:0]           a_d;
    logic [rv_isa_pkg::xlen-1:0]           b_d;
    logic [rv_isa_pkg::reg_idx_width-1:0]  rd_d;
    logic                                  accept;

    // youngest in-flight value wins, x0 never bypasses
    function automatic logic [rv_isa_pkg::xlen-1:0] bypass(
        input logic [rv_isa_pkg::reg_idx_width-1:0] sel,
        input logic [rv_isa_pkg::xlen-1:0]          rf_val
    );
        logic [rv_isa_pkg::xlen-1:0] val;
        val = rf_val;
        if (sel != '0) begin
            if (fwd_valid && fwd_rd == sel)
                val = fwd_data;
            else if (res_valid && res_rd == sel)
                val = res_data;
        end
        return val;
    endfunction

    assign inst_ready = rdy && (!dec_valid || ex_ready);
    assign accept     = inst_valid && inst_ready;

    assign rs1_sel = inst[19:15];
    assign rs2_sel = inst[24:20];

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = rv_isa_pkg::funct3_e'(inst[14:12]);
    assign alt    = (inst[31:25] == rv_isa_pkg::funct7_alt);
    assign imm_i  = {{(rv_isa_pkg::xlen-12){inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'b0};

    always_comb begin
        src1 = bypass(rs1_sel, rs1_data);
        src2 = bypass(rs2_sel, rs2_data);
    end

    always_comb begin
        op_d = core_pkg::alu_add;
        a_d  = src1;
        b_d  = imm_i;
        rd_d = inst[11:7];
        case (funct3)
            rv_isa_pkg::add_sub: begin
                // no subi exists, so alt only counts in register form
                if (opcode == rv_isa_pkg::op_op && alt)
                    op_d = core_pkg::alu_sub;
            end
            rv_isa_pkg::sll:     op_d = core_pkg::alu_sll;
            rv_isa_pkg::slt:     op_d = core_pkg::alu_slt;
            rv_isa_pkg::sltu:    op_d = core_pkg::alu_sltu;
            rv_isa_pkg::xor_op:  op_d = core_pkg::alu_xor;
            rv_isa_pkg::srl_sra: op_d = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            rv_isa_pkg::or_op:   op_d = core_pkg::alu_or;
            rv_isa_pkg::and_op:  op_d = core_pkg::alu_and;
            default:             op_d = core_pkg::alu_add;
        endcase
        case (opcode)
            rv_isa_pkg::op_op:  b_d = src2;
            rv_isa_pkg::op_imm: b_d = imm_i;
            rv_isa_pkg::op_lui: begin
                op_d = core_pkg::alu_add;  // 0 + imm
                a_d  = '0;
                b_d  = imm_u;
            end
            default: begin
                // unknown opcode retires as a harmless add to x0
                op_d = core_pkg::alu_add;
                rd_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else if (inst_ready)
            dec_valid <= inst_valid;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_op <= op_d;
            dec_a  <= a_d;
            dec_b  <= b_d;
            dec_rd <= rd_d;
        end
    end

endmodule

// File: src/execute_stage.sv
/* Execute stage: ALU on the decode register, result register and the
   commit handshake, which also writes the register file. */
`timescale 1ns/1ps

module execute_stage (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rdy,
    input  logic                                   dec_valid,
    input  core_pkg::alu_op_e                      dec_op,
    input  logic [rv_isa_pkg::xlen-1:0]            dec_a,
    input  logic [rv_isa_pkg::xlen-1:0]            dec_b,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   dec_rd,
    output logic                                   ex_ready,
    output logic                                   fwd_valid,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   fwd_rd,
    output logic [rv_isa_pkg::xlen-1:0]            fwd_data,
    output logic                                   res_valid,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   res_rd,
    output logic [rv_isa_pkg::xlen-1:0]            res_data,
    output logic                                   commit_valid,
    input  logic                                   commit_ready,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   commit_rd,
    output logic [rv_isa_pkg::xlen-1:0]            commit_data,
    output logic                                   wr_en,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   wr_sel,
    output logic [rv_isa_pkg::xlen-1:0]            wr_data
);

    logic [rv_isa_pkg::xlen-1:0] alu_out;
    logic [4:0]                  shamt;
    logic                        commit_fire;

    assign shamt = dec_b[4:0];

    always_comb begin
        case (dec_op)
            core_pkg::alu_add:  alu_out = dec_a + dec_b;
            core_pkg::alu_sub:  alu_out = dec_a - dec_b;
            core_pkg::alu_sll:  alu_out = dec_a << shamt;
            core_pkg::alu_slt:  alu_out = {31'b0, $signed(dec_a) < $signed(dec_b)};
            core_pkg::alu_sltu: alu_out = {31'b0, dec_a < dec_b};
            core_pkg::alu_xor:  alu_out = dec_a ^ dec_b;
            core_pkg::alu_srl:  alu_out = dec_a >> shamt;
            core_pkg::alu_sra:  alu_out = $signed(dec_a) >>> shamt;
            core_pkg::alu_or:   alu_out = dec_a | dec_b;
            core_pkg::alu_and:  alu_out = dec_a & dec_b;
            default:            alu_out = dec_a + dec_b;
        endcase
    end

    // result of the op sitting in the decode register
    assign fwd_valid = dec_valid;
    assign fwd_rd    = dec_rd;
    assign fwd_data  = alu_out;

    assign commit_valid = res_valid && rdy;   // nothing leaves while paused
    assign commit_fire  = commit_valid && commit_ready;
    assign commit_rd    = res_rd;
    assign commit_data  = res_data;

    // result register free now or emptied on this edge
    assign ex_ready = rdy && (!res_valid || commit_ready);

    assign wr_en   = commit_fire && (res_rd != '0);
    assign wr_sel  = res_rd;
    assign wr_data = res_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else if (ex_ready)
            res_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (ex_ready && dec_valid) begin
            res_rd   <= dec_rd;
            res_data <= alu_out;
        end
    end

endmodule

// File: src/register_file.sv
/* Architectural integer registers with two operand reads, one debug read
   and a single write port fed by the commit handshake. */
`timescale 1ns/1ps

module register_file (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wr_en,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   wr_sel,
    input  logic [rv_isa_pkg::xlen-1:0]            wr_data,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   rs1_sel,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   rs2_sel,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   dbg_sel,
    output logic [rv_isa_pkg::xlen-1:0]            rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]            rs2_data,
    output logic [rv_isa_pkg::xlen-1:0]            dbg_data
);

    logic [rv_isa_pkg::xlen-1:0] regs [rv_isa_pkg::num_regs];

    function automatic logic [rv_isa_pkg::xlen-1:0] rd_port(
        input logic [rv_isa_pkg::reg_idx_width-1:0] sel
    );
        return (sel == '0) ? '0 : regs[sel];  // x0 is hardwired
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_isa_pkg::num_regs; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // decode bypasses results that are written on the same edge
    always_comb begin
        rs1_data = rd_port(rs1_sel);
        rs2_data = rd_port(rs2_sel);
        dbg_data = rd_port(dbg_sel);
    end

endmodule

// File: src/rv_core.sv
/* Top of the in-order RV32I ALU core: decode, execute and register file.
   Instructions come in on inst_valid/inst_ready and retire on commit. */
`timescale 1ns/1ps

module rv_core (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   rdy,        // low freezes the core
    input  logic                                   inst_valid,
    output logic                                   inst_ready,
    input  logic [rv_isa_pkg::inst_width-1:0]      inst,
    output logic                                   commit_valid,
    input  logic                                   commit_ready,
    output logic [rv_isa_pkg::reg_idx_width-1:0]   commit_rd,
    output logic [rv_isa_pkg::xlen-1:0]            commit_data,
    input  logic [rv_isa_pkg::reg_idx_width-1:0]   dbg_sel,
    output logic [rv_isa_pkg::xlen-1:0]            dbg_data
);

    logic                                  dec_valid;
    core_pkg::alu_op_e                     dec_op;
    logic [rv_isa_pkg::xlen-1:0]           dec_a;
    logic [rv_isa_pkg::xlen-1:0]           dec_b;
    logic [rv_isa_pkg::reg_idx_width-1:0]  dec_rd;
    logic                                  ex_ready;
    logic                                  fwd_valid;
    logic [rv_isa_pkg::reg_idx_width-1:0]  fwd_rd;
    logic [rv_isa_pkg::xlen-1:0]           fwd_data;
    logic                                  res_valid;
    logic [rv_isa_pkg::reg_idx_width-1:0]  res_rd;
    logic [rv_isa_pkg::xlen-1:0]           res_data;
    logic [rv_isa_pkg::reg_idx_width-1:0]  rs1_sel;
    logic [rv_isa_pkg::reg_idx_width-1:0]  rs2_sel;
    logic [rv_isa_pkg::xlen-1:0]           rs1_data;
    logic [rv_isa_pkg::xlen-1:0]           rs2_data;
    logic                                  wr_en;
    logic [rv_isa_pkg::reg_idx_width-1:0]  wr_sel;
    logic [rv_isa_pkg::xlen-1:0]           wr_data;

    decode_stage i_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdy        (rdy),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .ex_ready   (ex_ready),
        .fwd_valid  (fwd_valid),
        .fwd_rd     (fwd_rd),
        .fwd_data   (fwd_data),
        .res_valid  (res_valid),
        .res_rd     (res_rd),
        .res_data   (res_data),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec_valid  (dec_valid),
        .dec_op     (dec_op),
        .dec_a      (dec_a),
        .dec_b      (dec_b),
        .dec_rd     (dec_rd)
    );

    execute_stage i_execute_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdy          (rdy),
        .dec_valid    (dec_valid),
        .dec_op       (dec_op),
        .dec_a        (dec_a),
        .dec_b        (dec_b),
        .dec_rd       (dec_rd),
        .ex_ready     (ex_ready),
        .fwd_valid    (fwd_valid),
        .fwd_rd       (fwd_rd),
        .fwd_data     (fwd_data),
        .res_valid    (res_valid),
        .res_rd       (res_rd),
        .res_data     (res_data),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .wr_en        (wr_en),
        .wr_sel       (wr_sel),
        .wr_data      (wr_data)
    );

    register_file i_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .dbg_sel  (dbg_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

endmodule

// File: src/rv_isa_pkg.sv
/* RV32I encoding facts shared by the decoder and the register file.
   Only the OP, OP-IMM and LUI formats are described here. */
package rv_isa_pkg;

    localparam int xlen          = 32;
    localparam int inst_width    = 32;
    localparam int num_regs      = 32;
    localparam int reg_idx_width = 5;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_op  = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // inst[14:12] for the integer ALU group
    typedef enum logic [2:0] {
        add_sub = 3'b000,
        sll     = 3'b001,
        slt     = 3'b010,
        sltu    = 3'b011,
        xor_op  = 3'b100,
        srl_sra = 3'b101,
        or_op   = 3'b110,
        and_op  = 3'b111
    } funct3_e;

    // inst[31:25] value that turns add into sub and srl into sra
    localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage
